//--- src/issue_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared sizes and packed types for the issue stage
// referenced as issue_pkg::name by every RTL file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package issue_pkg;

    // execution slots: 0 alu, 1 scalar ld/st, 2 branch, 3 matrix ld/st, 4 gemm
    localparam int NSLOTS = 5;
    // scalar table rows, addressed directly by slot 0..2
    localparam int NSCALAR = 3;

    // slot index as carried by dispatch and the issue packet
    typedef logic [2:0] slot_t;

    // matrix slots, the scalar ones sit at 0..NSCALAR-1
    localparam slot_t FU_MLS = 3'd3;
    localparam slot_t FU_GEMM = 3'd4;

    // producer tag, 0 = available, k = slot k-1 still owes the value
    typedef logic [2:0] tag_t;
    typedef logic [4:0] regbits_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] matbits_t;

    // per-slot status
    typedef enum logic [1:0] {
        EMPTY,
        WAIT,
        RDY,
        EX
    } slot_state_e;

    // scalar table payload
    typedef struct packed {
        regbits_t rs1;
        regbits_t rs2;
    } s_row_t;

    // matrix ld/st payload, address operands come from scalar regs
    typedef struct packed {
        regbits_t rs1;
        regbits_t rs2;
    } m_row_t;

    // gemm payload, three matrix register ids
    typedef struct packed {
        matbits_t ms1;
        matbits_t ms2;
        matbits_t ms3;
    } g_row_t;

    // writeback broadcast, tag frees a slot and wakes consumers
    typedef struct packed {
        logic valid;
        tag_t tag;
        logic rd_en;
        regbits_t rd;
        word_t wdata;
    } wb_t;

    // registered packet towards execute
    typedef struct packed {
        logic valid;
        slot_t fu;
        word_t rdat1;
        word_t rdat2;
        matbits_t ms1;
        matbits_t ms2;
        matbits_t ms3;
    } issue_t;

    // one dispatched instruction, only the row of the target slot matters
    typedef struct packed {
        logic en;
        slot_t slot;
        tag_t t1;
        tag_t t2;
        // t3 only meaningful for gemm
        tag_t t3;
        s_row_t s_row;
        m_row_t m_row;
        g_row_t g_row;
    } dispatch_t;

endpackage

//--- src/regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scalar register file, 2 read / 1 write, written by writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regfile (
    input logic CLK,
    input logic nRST,
    input logic wen,
    input issue_pkg::regbits_t wsel,
    input issue_pkg::word_t wdata,
    input issue_pkg::regbits_t rsel1,
    input issue_pkg::regbits_t rsel2,
    output issue_pkg::word_t rdat1,
    output issue_pkg::word_t rdat2
);

    issue_pkg::word_t regs [32];

    // x0 is never written, it stays at its reset value
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdata;
        end
    end

    // reads see a same-cycle write so a consumer woken by
    // this writeback picks up the fresh value
    always_comb begin
        if (rsel1 == '0) begin
            rdat1 = '0;
        end else if (wen && wsel == rsel1) begin
            rdat1 = wdata;
        end else begin
            rdat1 = regs[rsel1];
        end
        if (rsel2 == '0) begin
            rdat2 = '0;
        end else if (wen && wsel == rsel2) begin
            rdat2 = wdata;
        end else begin
            rdat2 = regs[rsel2];
        end
    end

endmodule

//--- src/fust.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// functional unit status table, payload plus source tags per row
// one instance per table kind, row type and source count as parameters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fust #(
    parameter int ROWS = 1,
    parameter int NSRC = 2,
    parameter type row_t = issue_pkg::s_row_t
) (
    input logic CLK,
    input logic nRST,
    input logic [ROWS-1:0] wen,
    input row_t wrow,
    input issue_pkg::tag_t [2:0] wtags,
    input issue_pkg::wb_t wb,
    output row_t [ROWS-1:0] rows,
    output logic [ROWS-1:0] ready
);

    issue_pkg::tag_t [ROWS-1:0][2:0] tags;
    // stored tags with this cycle's broadcast already removed
    issue_pkg::tag_t [ROWS-1:0][2:0] tags_live;
    issue_pkg::tag_t [2:0] wtags_live;

    // drop a tag that matches the live writeback
    function automatic issue_pkg::tag_t squash(input issue_pkg::tag_t t,
                                               input issue_pkg::wb_t w);
        return (w.valid && t == w.tag) ? '0 : t;
    endfunction

    always_comb begin
        // sources past NSRC are kept at zero so they never block
        for (int s = 0; s < 3; s++) begin
            wtags_live[s] = (s < NSRC) ? squash(wtags[s], wb) : '0;
        end
        // ready already counts the broadcast, so a consumer can be picked
        // in the same cycle its last producer writes back
        for (int r = 0; r < ROWS; r++) begin
            ready[r] = 1'b1;
            for (int s = 0; s < 3; s++) begin
                tags_live[r][s] = squash(tags[r][s], wb);
                ready[r] = ready[r] & (tags_live[r][s] == '0);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tags <= '0;
        end else begin
            for (int r = 0; r < ROWS; r++) begin
                tags[r] <= wen[r] ? wtags_live : tags_live[r];
            end
        end
    end

    // payload only moves on dispatch
    always_ff @(posedge CLK) begin
        for (int r = 0; r < ROWS; r++) begin
            if (wen[r]) begin
                rows[r] <= wrow;
            end
        end
    end

endmodule

//--- src/issue_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot state machines, relative ages and oldest-ready pick
// issue_onehot is combinational, the caller registers the packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_select (
    input logic CLK,
    input logic nRST,
    input logic [issue_pkg::NSLOTS-1:0] dispatch,
    input logic [issue_pkg::NSLOTS-1:0] operands_ready,
    input issue_pkg::wb_t wb,
    input logic freeze,
    output logic [issue_pkg::NSLOTS-1:0] issue_onehot,
    output logic [issue_pkg::NSLOTS-1:0] busy,
    output issue_pkg::slot_state_e [issue_pkg::NSLOTS-1:0] slot_state
);

    issue_pkg::slot_state_e [issue_pkg::NSLOTS-1:0] state;
    issue_pkg::slot_state_e [issue_pkg::NSLOTS-1:0] n_state;

    // ages of occupied slots are kept distinct and below NSLOTS
    logic [issue_pkg::NSLOTS-1:0][2:0] age;
    logic [issue_pkg::NSLOTS-1:0][2:0] n_age;

    // slot completes this cycle
    logic [issue_pkg::NSLOTS-1:0] done;
    // waiting with all operands, before arbitration
    logic [issue_pkg::NSLOTS-1:0] eligible;
    logic [2:0] best_age;
    logic found;

    always_comb begin
        for (int i = 0; i < issue_pkg::NSLOTS; i++) begin
            done[i] = wb.valid && state[i] == issue_pkg::EX
                      && wb.tag == issue_pkg::tag_t'(i + 1);
            eligible[i] = (state[i] == issue_pkg::WAIT || state[i] == issue_pkg::RDY)
                          && operands_ready[i];
        end
    end

    // oldest eligible wins, at most one per cycle
    // strict compare is enough since occupied ages never collide
    always_comb begin
        issue_onehot = '0;
        best_age = '0;
        found = 1'b0;
        if (!freeze) begin
            for (int i = 0; i < issue_pkg::NSLOTS; i++) begin
                if (eligible[i] && (!found || age[i] > best_age)) begin
                    found = 1'b1;
                    best_age = age[i];
                    issue_onehot = '0;
                    issue_onehot[i] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        n_state = state;
        for (int i = 0; i < issue_pkg::NSLOTS; i++) begin
            case (state[i])
                issue_pkg::EMPTY: begin
                    if (dispatch[i]) begin
                        n_state[i] = issue_pkg::WAIT;
                    end
                end
                issue_pkg::WAIT: begin
                    // lost arbitration or frozen, park in RDY
                    if (issue_onehot[i]) begin
                        n_state[i] = issue_pkg::EX;
                    end else if (operands_ready[i]) begin
                        n_state[i] = issue_pkg::RDY;
                    end
                end
                issue_pkg::RDY: begin
                    if (issue_onehot[i]) begin
                        n_state[i] = issue_pkg::EX;
                    end
                end
                issue_pkg::EX: begin
                    if (done[i]) begin
                        n_state[i] = issue_pkg::EMPTY;
                    end
                end
                default: n_state[i] = issue_pkg::EMPTY;
            endcase
        end
    end

    // new entry gets 0 and pushes every occupied slot up by one,
    // a completing slot pulls everything older than it down by one
    always_comb begin
        for (int i = 0; i < issue_pkg::NSLOTS; i++) begin
            n_age[i] = age[i];
            if (dispatch[i] || done[i] || state[i] == issue_pkg::EMPTY) begin
                n_age[i] = '0;
            end else begin
                if (|dispatch) begin
                    n_age[i] = n_age[i] + 3'd1;
                end
                for (int j = 0; j < issue_pkg::NSLOTS; j++) begin
                    if (done[j] && age[j] < age[i]) begin
                        n_age[i] = n_age[i] - 3'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= {issue_pkg::NSLOTS{issue_pkg::EMPTY}};
            age <= '0;
        end else begin
            state <= n_state;
            age <= n_age;
        end
    end

    always_comb begin
        for (int i = 0; i < issue_pkg::NSLOTS; i++) begin
            busy[i] = state[i] != issue_pkg::EMPTY;
        end
    end

    assign slot_state = state;

endmodule

//--- src/issue_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage top, status tables + selector + scalar regfile
// out is registered and held while freeze is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_stage (
    input logic CLK,
    input logic nRST,
    input issue_pkg::dispatch_t disp,
    input issue_pkg::wb_t wb,
    input logic freeze,
    output issue_pkg::issue_t out,
    output logic [issue_pkg::NSLOTS-1:0] busy,
    output issue_pkg::slot_state_e [issue_pkg::NSLOTS-1:0] slot_state
);

    logic [issue_pkg::NSLOTS-1:0] disp_onehot;
    logic [issue_pkg::NSLOTS-1:0] issue_onehot;
    logic [issue_pkg::NSLOTS-1:0] operands_ready;
    issue_pkg::tag_t [2:0] disp_tags;

    issue_pkg::s_row_t [issue_pkg::NSCALAR-1:0] s_rows;
    issue_pkg::m_row_t [0:0] m_rows;
    issue_pkg::g_row_t [0:0] g_rows;
    logic [issue_pkg::NSCALAR-1:0] s_ready;
    logic m_ready;
    logic g_ready;

    issue_pkg::regbits_t rs1;
    issue_pkg::regbits_t rs2;
    issue_pkg::word_t rdat1;
    issue_pkg::word_t rdat2;
    issue_pkg::issue_t n_out;

    // slot number to one-hot, scalar rows are addressed by the same bits
    assign disp_onehot = disp.en ? issue_pkg::NSLOTS'(1) << disp.slot : '0;
    assign disp_tags = {disp.t3, disp.t2, disp.t1};

    fust #(.ROWS(issue_pkg::NSCALAR), .NSRC(2), .row_t(issue_pkg::s_row_t)) u_fust_s (
        .CLK(CLK), .nRST(nRST),
        .wen(disp_onehot[issue_pkg::NSCALAR-1:0]),
        .wrow(disp.s_row), .wtags(disp_tags), .wb(wb),
        .rows(s_rows), .ready(s_ready)
    );

    fust #(.ROWS(1), .NSRC(2), .row_t(issue_pkg::m_row_t)) u_fust_m (
        .CLK(CLK), .nRST(nRST),
        .wen(disp_onehot[issue_pkg::FU_MLS]),
        .wrow(disp.m_row), .wtags(disp_tags), .wb(wb),
        .rows(m_rows), .ready(m_ready)
    );

    // gemm is the only table that tracks a third source
    fust #(.ROWS(1), .NSRC(3), .row_t(issue_pkg::g_row_t)) u_fust_g (
        .CLK(CLK), .nRST(nRST),
        .wen(disp_onehot[issue_pkg::FU_GEMM]),
        .wrow(disp.g_row), .wtags(disp_tags), .wb(wb),
        .rows(g_rows), .ready(g_ready)
    );

    assign operands_ready = {g_ready, m_ready, s_ready};

    issue_select u_select (
        .CLK(CLK), .nRST(nRST),
        .dispatch(disp_onehot), .operands_ready(operands_ready),
        .wb(wb), .freeze(freeze),
        .issue_onehot(issue_onehot), .busy(busy), .slot_state(slot_state)
    );

    regfile u_regfile (
        .CLK(CLK), .nRST(nRST),
        .wen(wb.valid & wb.rd_en), .wsel(wb.rd), .wdata(wb.wdata),
        .rsel1(rs1), .rsel2(rs2),
        .rdat1(rdat1), .rdat2(rdat2)
    );

    // steer the winner's sources to the read ports
    // gemm reads x0, its operands are matrix ids
    always_comb begin
        rs1 = '0;
        rs2 = '0;
        for (int i = 0; i < issue_pkg::NSCALAR; i++) begin
            if (issue_onehot[i]) begin
                rs1 = s_rows[i].rs1;
                rs2 = s_rows[i].rs2;
            end
        end
        if (issue_onehot[issue_pkg::FU_MLS]) begin
            rs1 = m_rows[0].rs1;
            rs2 = m_rows[0].rs2;
        end
    end

    // packet for the slot entering EX, all zero when none does
    always_comb begin
        n_out = '0;
        for (int i = 0; i < issue_pkg::NSLOTS; i++) begin
            if (issue_onehot[i]) begin
                n_out.valid = 1'b1;
                n_out.fu = issue_pkg::slot_t'(i);
                n_out.rdat1 = rdat1;
                n_out.rdat2 = rdat2;
            end
        end
        if (issue_onehot[issue_pkg::FU_GEMM]) begin
            n_out.ms1 = g_rows[0].ms1;
            n_out.ms2 = g_rows[0].ms2;
            n_out.ms3 = g_rows[0].ms3;
        end
    end

    // freeze keeps the last packet on the bus
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else if (!freeze) begin
            out <= n_out;
        end
    end

endmodule

//--- verification/issue_stage_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage testbench, one table row per clock cycle
// expected packets are rebuilt from a model of the scalar registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_stage_tb;

    typedef issue_pkg::slot_state_e [issue_pkg::NSLOTS-1:0] states_t;

    // one cycle of stimulus plus what the outputs show in that cycle
    typedef struct packed {
        issue_pkg::dispatch_t disp;
        issue_pkg::wb_t wb;
        logic freeze;
        logic exp_valid;
        issue_pkg::slot_t exp_fu;
        issue_pkg::regbits_t exp_rs1;
        issue_pkg::regbits_t exp_rs2;
        issue_pkg::g_row_t exp_ms;
        logic [issue_pkg::NSLOTS-1:0] exp_busy;
        states_t exp_state;
    } step_t;

    localparam issue_pkg::dispatch_t NO_DISP = '0;
    localparam issue_pkg::wb_t NO_WB = '0;
    localparam issue_pkg::g_row_t NO_MS = '0;

    logic CLK;
    logic nRST;
    issue_pkg::dispatch_t disp;
    issue_pkg::wb_t wb;
    logic freeze;
    issue_pkg::issue_t out;
    logic [issue_pkg::NSLOTS-1:0] busy;
    issue_pkg::slot_state_e [issue_pkg::NSLOTS-1:0] slot_state;

    step_t steps[$];
    string names[$];
    // scalar registers as the DUT should hold them
    issue_pkg::word_t model_regs [32];
    int issue_errors;
    int busy_errors;
    int state_errors;
    int cycles;

    issue_stage uut (
        .CLK(CLK), .nRST(nRST),
        .disp(disp), .wb(wb), .freeze(freeze),
        .out(out), .busy(busy), .slot_state(slot_state)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // scalar slots 0..2 and matrix ld/st, two register sources
    function automatic issue_pkg::dispatch_t scalar_disp(input issue_pkg::slot_t slot,
                                                         input issue_pkg::tag_t t1,
                                                         input issue_pkg::tag_t t2,
                                                         input issue_pkg::regbits_t rs1,
                                                         input issue_pkg::regbits_t rs2);
        issue_pkg::dispatch_t d;
        d = '0;
        d.en = 1'b1;
        d.slot = slot;
        d.t1 = t1;
        d.t2 = t2;
        if (slot == issue_pkg::FU_MLS) begin
            d.m_row.rs1 = rs1;
            d.m_row.rs2 = rs2;
        end else begin
            d.s_row.rs1 = rs1;
            d.s_row.rs2 = rs2;
        end
        return d;
    endfunction

    function automatic issue_pkg::dispatch_t gemm_disp(input issue_pkg::tag_t t1,
                                                       input issue_pkg::tag_t t2,
                                                       input issue_pkg::tag_t t3,
                                                       input issue_pkg::g_row_t ms);
        issue_pkg::dispatch_t d;
        d = '0;
        d.en = 1'b1;
        d.slot = issue_pkg::FU_GEMM;
        d.t1 = t1;
        d.t2 = t2;
        d.t3 = t3;
        d.g_row = ms;
        return d;
    endfunction

    // wdata is left at zero here, the run loop draws it
    function automatic issue_pkg::wb_t bcast(input issue_pkg::tag_t tag, input logic rd_en,
                                             input issue_pkg::regbits_t rd);
        issue_pkg::wb_t w;
        w = '0;
        w.valid = 1'b1;
        w.tag = tag;
        w.rd_en = rd_en;
        w.rd = rd;
        return w;
    endfunction

    // one letter per slot from slot 4 down to slot 0
    // W wait, R rdy, X ex, anything else empty
    function automatic states_t decode_states(input string code);
        states_t st;
        for (int i = 0; i < issue_pkg::NSLOTS; i++) begin
            case (code[issue_pkg::NSLOTS-1-i])
                "W": st[i] = issue_pkg::WAIT;
                "R": st[i] = issue_pkg::RDY;
                "X": st[i] = issue_pkg::EX;
                default: st[i] = issue_pkg::EMPTY;
            endcase
        end
        return st;
    endfunction

    task automatic add_step(input string name, input issue_pkg::dispatch_t d,
                            input issue_pkg::wb_t w, input logic frz, input logic ev,
                            input issue_pkg::slot_t efu, input issue_pkg::regbits_t ers1,
                            input issue_pkg::regbits_t ers2, input issue_pkg::g_row_t ems,
                            input logic [issue_pkg::NSLOTS-1:0] ebusy, input string est);
        step_t s;
        s.disp = d;
        s.wb = w;
        s.freeze = frz;
        s.exp_valid = ev;
        s.exp_fu = efu;
        s.exp_rs1 = ers1;
        s.exp_rs2 = ers2;
        s.exp_ms = ems;
        s.exp_busy = ebusy;
        s.exp_state = decode_states(est);
        steps.push_back(s);
        names.push_back(name);
    endtask

    // expected columns show the packet picked one cycle earlier
    task automatic build_table();
        // tag 5 writebacks while gemm is empty only fill registers
        add_step("reset", NO_DISP, bcast(3'd5, 1'b1, 5'd1), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
        add_step("preload r2", NO_DISP, bcast(3'd5, 1'b1, 5'd2), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
        add_step("preload r3", NO_DISP, bcast(3'd5, 1'b1, 5'd3), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
        add_step("alu dispatch", scalar_disp(3'd0, 3'd0, 3'd0, 5'd1, 5'd2), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
        // branch waits on the alu through t1
        add_step("branch behind alu", scalar_disp(3'd2, 3'd1, 3'd0, 5'd3, 5'd1), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00001, "....W");
        add_step("alu issued", NO_DISP, NO_WB, 1'b0,
                 1'b1, 3'd0, 5'd1, 5'd2, NO_MS, 5'b00101, "..W.X");
        add_step("alu writeback", NO_DISP, bcast(3'd1, 1'b1, 5'd3), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00101, "..W.X");
        // rdat1 is the bypassed r3 from the tag 1 writeback
        add_step("branch bypass", NO_DISP, bcast(3'd3, 1'b0, 5'd0), 1'b0,
                 1'b1, 3'd2, 5'd3, 5'd1, NO_MS, 5'b00100, "..X..");
        add_step("age alu", scalar_disp(3'd0, 3'd0, 3'd0, 5'd2, 5'd0), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
        add_step("age ldst", scalar_disp(3'd1, 3'd1, 3'd0, 5'd1, 5'd3), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00001, "....W");
        add_step("age branch", scalar_disp(3'd2, 3'd0, 3'd1, 5'd2, 5'd4), NO_WB, 1'b0,
                 1'b1, 3'd0, 5'd2, 5'd0, NO_MS, 5'b00011, "...WX");
        // one broadcast wakes both, the older ld/st wins
        add_step("age wake", NO_DISP, bcast(3'd1, 1'b1, 5'd4), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00111, "..WWX");
        add_step("age ldst first", NO_DISP, NO_WB, 1'b0,
                 1'b1, 3'd1, 5'd1, 5'd3, NO_MS, 5'b00110, "..RX.");
        add_step("age branch next", NO_DISP, bcast(3'd2, 1'b1, 5'd5), 1'b0,
                 1'b1, 3'd2, 5'd2, 5'd4, NO_MS, 5'b00110, "..XX.");
        add_step("age drain", NO_DISP, bcast(3'd3, 1'b0, 5'd0), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00100, "..X..");
        // branch now goes in before ld/st, so the older slot has the higher index
        add_step("order alu", scalar_disp(3'd0, 3'd0, 3'd0, 5'd3, 5'd4), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
        add_step("order branch", scalar_disp(3'd2, 3'd1, 3'd0, 5'd4, 5'd2), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00001, "....W");
        add_step("order ldst", scalar_disp(3'd1, 3'd1, 3'd0, 5'd2, 5'd3), NO_WB, 1'b0,
                 1'b1, 3'd0, 5'd3, 5'd4, NO_MS, 5'b00101, "..W.X");
        // rdat2 of the branch is the bypassed r2
        add_step("order wake", NO_DISP, bcast(3'd1, 1'b1, 5'd2), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00111, "..WWX");
        add_step("order branch first", NO_DISP, NO_WB, 1'b0,
                 1'b1, 3'd2, 5'd4, 5'd2, NO_MS, 5'b00110, "..XR.");
        add_step("order ldst next", NO_DISP, bcast(3'd3, 1'b0, 5'd0), 1'b0,
                 1'b1, 3'd1, 5'd2, 5'd3, NO_MS, 5'b00110, "..XX.");
        add_step("order drain", NO_DISP, bcast(3'd2, 1'b0, 5'd0), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00010, "...X.");
        add_step("frz alu", scalar_disp(3'd0, 3'd0, 3'd0, 5'd5, 5'd1), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
        add_step("frz ldst", scalar_disp(3'd1, 3'd0, 3'd0, 5'd4, 5'd5), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00001, "....W");
        add_step("frz on", NO_DISP, NO_WB, 1'b1,
                 1'b1, 3'd0, 5'd5, 5'd1, NO_MS, 5'b00011, "...WX");
        // r5 changes under freeze, the held packet keeps the old value
        add_step("frz hold wb", NO_DISP, bcast(3'd1, 1'b1, 5'd5), 1'b1,
                 1'b1, 3'd0, 5'd5, 5'd1, NO_MS, 5'b00011, "...RX");
        add_step("frz off", NO_DISP, NO_WB, 1'b0,
                 1'b1, 3'd0, 5'd5, 5'd1, NO_MS, 5'b00010, "...R.");
        add_step("frz ldst issued", NO_DISP, bcast(3'd2, 1'b0, 5'd0), 1'b0,
                 1'b1, 3'd1, 5'd4, 5'd5, NO_MS, 5'b00010, "...X.");
        add_step("mat ldst", scalar_disp(3'd3, 3'd0, 3'd0, 5'd1, 5'd2), NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
        // gemm waits on the matrix load through t3
        add_step("gemm dispatch", gemm_disp(3'd0, 3'd0, 3'd4, {4'd3, 4'd7, 4'd12}), NO_WB,
                 1'b0, 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b01000, ".W...");
        add_step("mat ldst issued", NO_DISP, NO_WB, 1'b0,
                 1'b1, 3'd3, 5'd1, 5'd2, NO_MS, 5'b11000, "WX...");
        add_step("mat wb", NO_DISP, bcast(3'd4, 1'b0, 5'd0), 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b11000, "WX...");
        add_step("gemm issued", NO_DISP, bcast(3'd5, 1'b0, 5'd0), 1'b0,
                 1'b1, 3'd4, 5'd0, 5'd0, {4'd3, 4'd7, 4'd12}, 5'b10000, "X....");
        add_step("idle", NO_DISP, NO_WB, 1'b0,
                 1'b0, 3'd0, 5'd0, 5'd0, NO_MS, 5'b00000, ".....");
    endtask

    // x0 is never written in the model, so it reads zero
    function automatic issue_pkg::issue_t expect_packet(input step_t s);
        issue_pkg::issue_t p;
        p = '0;
        if (s.exp_valid) begin
            p.valid = 1'b1;
            p.fu = s.exp_fu;
            p.rdat1 = model_regs[s.exp_rs1];
            p.rdat2 = model_regs[s.exp_rs2];
            p.ms1 = s.exp_ms.ms1;
            p.ms2 = s.exp_ms.ms2;
            p.ms3 = s.exp_ms.ms3;
        end
        return p;
    endfunction

    task automatic check_issue(input string name, input issue_pkg::issue_t exp,
                               input issue_pkg::issue_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: out expected %h actual %h", name, exp, act);
            issue_errors++;
        end
    endtask

    task automatic check_busy(input string name, input logic [issue_pkg::NSLOTS-1:0] exp,
                              input logic [issue_pkg::NSLOTS-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: busy expected %b actual %b", name, exp, act);
            busy_errors++;
        end
    endtask

    task automatic check_state(input string name, input states_t exp, input states_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: slot_state expected %b actual %b", name, exp, act);
            state_errors++;
        end
    endtask

    // limit is the table length plus slack, counted from reset release
    initial begin
        cycles = 0;
        @(posedge nRST);
        forever begin
            @(posedge CLK);
            cycles++;
            if (cycles > steps.size() + 20) begin
                $display("timeout: table did not finish");
                $display("=== FAIL ===");
                $finish;
            end
        end
    end

    initial begin
        issue_pkg::wb_t cur_wb;
        issue_pkg::issue_t exp_out;
        issue_pkg::issue_t last_exp;
        logic prev_freeze;
        void'($urandom(32'h33f9));
        nRST = 1'b0;
        disp = '0;
        wb = '0;
        freeze = 1'b0;
        issue_errors = 0;
        busy_errors = 0;
        state_errors = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_table();
        repeat (8) @(posedge CLK);
        #2;
        nRST = 1'b1;
        last_exp = '0;
        prev_freeze = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge CLK);
            #2;
            cur_wb = steps[i].wb;
            if (cur_wb.valid) begin
                cur_wb.wdata = $urandom();
            end
            disp = steps[i].disp;
            wb = cur_wb;
            freeze = steps[i].freeze;
            @(negedge CLK);
            // a frozen cycle leaves the packet of the cycle before
            if (prev_freeze) begin
                exp_out = last_exp;
            end else begin
                exp_out = expect_packet(steps[i]);
            end
            check_issue(names[i], exp_out, out);
            check_busy(names[i], steps[i].exp_busy, busy);
            check_state(names[i], steps[i].exp_state, slot_state);
            // register write lands at the coming edge
            if (cur_wb.valid && cur_wb.rd_en && cur_wb.rd != '0) begin
                model_regs[cur_wb.rd] = cur_wb.wdata;
            end
            last_exp = exp_out;
            prev_freeze = steps[i].freeze;
        end
        $display("errors: issue %0d, busy %0d, state %0d", issue_errors, busy_errors,
                 state_errors);
        if (issue_errors == 0 && busy_errors == 0 && state_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- list.f
src/issue_pkg.sv
src/regfile.sv
src/fust.sv
src/issue_select.sv
src/issue_stage.sv
verification/issue_stage_tb.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  - src/issue_pkg.sv
  - src/regfile.sv
  - src/fust.sv
  - src/issue_select.sv
  - src/issue_stage.sv
  - target: test
    files:
      - verification/issue_stage_tb.sv
